// File: verilog/pkt_q_pkg.sv
package pkt_q_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int DATA_W        = 32;
    localparam int BUF_WORDS     = 4;
    localparam int NUM_BUFS      = 16;
    localparam int PTR_W         = $clog2(NUM_BUFS);
    localparam int OFS_W         = $clog2(BUF_WORDS);
    localparam int ADDR_W        = PTR_W + OFS_W;

    // Whole buffer pool, the largest packet that fits
    localparam int MAX_PKT_WORDS = NUM_BUFS * BUF_WORDS;
    localparam int LEN_W         = $clog2(MAX_PKT_WORDS + 1);

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [PTR_W-1:0]  ptr_t;
    typedef logic [LEN_W-1:0]  len_t;

    // Buffer pointer in the upper bits, word offset in the lower bits
    typedef logic [ADDR_W-1:0] addr_t;

    // Gather FSM
    typedef enum logic [1:0] {
        GATHER_IDLE,
        GATHER_WALK,
        GATHER_DRAIN
    } gather_state_e;

endpackage : pkt_q_pkg

// File: verilog/buf_mem_if.sv
`timescale 1ns/1ns

interface buf_mem_if;
    import pkt_q_pkg::*;

    // Data write, from scatter
    logic  data_wr_en;
    addr_t data_wr_addr;
    data_t data_wr_data;

    // Link write, from scatter
    logic  link_wr_en;
    ptr_t  link_wr_ptr;
    ptr_t  link_wr_next;

    // Data read, one cycle latency
    addr_t data_rd_addr;
    data_t data_rd_data;

    // Link read, combinational
    ptr_t  link_rd_ptr;
    ptr_t  link_rd_next;

    modport scatter (
        output data_wr_en, data_wr_addr, data_wr_data,
        output link_wr_en, link_wr_ptr, link_wr_next
    );

    modport gather (
        output data_rd_addr, link_rd_ptr,
        input  data_rd_data, link_rd_next
    );

    modport store (
        input  data_wr_en, data_wr_addr, data_wr_data,
        input  link_wr_en, link_wr_ptr, link_wr_next,
        input  data_rd_addr, link_rd_ptr,
        output data_rd_data, link_rd_next
    );

endinterface : buf_mem_if

// File: verilog/buf_store.sv
`timescale 1ns/1ns

module buf_store (
    input  logic      clk,
    buf_mem_if.store  mem
);
    import pkt_q_pkg::*;

    // ------------------------------
    // Storage
    // ------------------------------
    // One row per word, BUF_WORDS consecutive rows per buffer
    data_t data_mem [NUM_BUFS * BUF_WORDS];

    // Next buffer of each buffer in its chain
    ptr_t  link_mem [NUM_BUFS];

    // ------------------------------
    // Packet data
    // ------------------------------
    always_ff @(posedge clk) begin
        if (mem.data_wr_en) begin
            data_mem[mem.data_wr_addr] <= mem.data_wr_data;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        mem.data_rd_data <= data_mem[mem.data_rd_addr];
    end

    // ------------------------------
    // Link table
    // ------------------------------
    always_ff @(posedge clk) begin
        if (mem.link_wr_en) begin
            link_mem[mem.link_wr_ptr] <= mem.link_wr_next;
        end
    end

    // Gather follows the chain in the same cycle
    assign mem.link_rd_next = link_mem[mem.link_rd_ptr];

endmodule : buf_store

// File: verilog/buf_allocator.sv
`timescale 1ns/1ns

module buf_allocator (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_take,
    input  logic            i_free,
    input  pkt_q_pkg::ptr_t i_free_ptr,
    output pkt_q_pkg::ptr_t o_head_ptr,
    output logic            o_empty,
    output logic            o_init_done
);
    import pkt_q_pkg::*;

    // Circular list of free buffer pointers, deep enough for all of them
    ptr_t             free_list [NUM_BUFS];
    ptr_t             rd_idx;
    ptr_t             wr_idx;
    logic [PTR_W:0]   count;

    // Post-reset fill
    ptr_t             fill_ptr;

    logic             push;
    logic             pop;
    ptr_t             push_ptr;

    // Fill writes every pointer once, then only frees push
    assign push     = !o_init_done || i_free;
    assign push_ptr = o_init_done ? i_free_ptr : fill_ptr;
    assign pop      = i_take && !o_empty;

    assign o_empty    = (count == '0);
    assign o_head_ptr = free_list[rd_idx];

    always_ff @(posedge clk) begin
        if (push) begin
            free_list[wr_idx] <= push_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            rd_idx      <= '0;
            wr_idx      <= '0;
            count       <= '0;
            fill_ptr    <= '0;
            o_init_done <= 1'b0;
        end else begin
            if (!o_init_done) begin
                fill_ptr <= fill_ptr + 1'b1;
                if (fill_ptr == ptr_t'(NUM_BUFS - 1)) begin
                    o_init_done <= 1'b1;
                end
            end
            // Indices wrap on their own, NUM_BUFS is a power of two
            if (push) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : buf_allocator

// File: verilog/pkt_scatter.sv
`timescale 1ns/1ns

module pkt_scatter (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_init_done,
    input  logic             i_pkt_valid,
    input  pkt_q_pkg::data_t i_pkt_data,
    input  logic             i_pkt_eop,
    input  logic             i_pkt_err,
    input  pkt_q_pkg::ptr_t  i_head_ptr,
    input  logic             i_empty,
    output logic             o_take,
    output logic             o_desc_valid,
    output pkt_q_pkg::ptr_t  o_desc_ptr,
    output pkt_q_pkg::len_t  o_desc_len,
    output logic             o_desc_err,
    buf_mem_if.scatter       mem
);
    import pkt_q_pkg::*;

    // Packet context
    logic             in_pkt;
    logic [OFS_W-1:0] ofs;
    ptr_t             cur_ptr;
    ptr_t             head_ptr;
    len_t             word_cnt;
    logic             exhausted;

    logic             word_in;
    logic             need_buf;
    logic             starved;
    logic             store_ok;
    ptr_t             wr_ptr;

    // ------------------------------
    // Word decode
    // ------------------------------
    // Nothing is accepted until the free list is filled
    assign word_in  = i_pkt_valid && i_init_done;

    // Offset zero means start of packet or previous buffer full
    assign need_buf = (ofs == '0);
    assign starved  = word_in && need_buf && i_empty && !exhausted;
    assign store_ok = word_in && !exhausted && !(need_buf && i_empty);
    assign wr_ptr   = need_buf ? i_head_ptr : cur_ptr;

    assign o_take   = store_ok && need_buf;

    // ------------------------------
    // Memory writes
    // ------------------------------
    assign mem.data_wr_en   = store_ok;
    assign mem.data_wr_addr = {wr_ptr, ofs};
    assign mem.data_wr_data = i_pkt_data;

    // Chain the previous buffer to the one just taken
    assign mem.link_wr_en   = o_take && in_pkt;
    assign mem.link_wr_ptr  = cur_ptr;
    assign mem.link_wr_next = i_head_ptr;

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            in_pkt       <= 1'b0;
            ofs          <= '0;
            word_cnt     <= '0;
            exhausted    <= 1'b0;
            o_desc_valid <= 1'b0;
        end else begin
            o_desc_valid <= word_in && i_pkt_eop;
            if (word_in) begin
                if (i_pkt_eop) begin
                    in_pkt    <= 1'b0;
                    ofs       <= '0;
                    word_cnt  <= '0;
                    exhausted <= 1'b0;
                end else begin
                    in_pkt <= 1'b1;
                    if (store_ok) begin
                        ofs      <= ofs + 1'b1;
                        word_cnt <= word_cnt + 1'b1;
                    end
                    // Out of buffers, drop the rest of the packet
                    if (starved) begin
                        exhausted <= 1'b1;
                    end
                end
            end
        end
    end

    // Buffer pointers and descriptor fields
    always_ff @(posedge clk) begin
        if (store_ok) begin
            cur_ptr <= wr_ptr;
        end
        if (word_in && !in_pkt) begin
            head_ptr <= i_head_ptr;
        end
        if (word_in && i_pkt_eop) begin
            o_desc_ptr <= in_pkt ? head_ptr : i_head_ptr;
            o_desc_len <= word_cnt + len_t'(store_ok);
            o_desc_err <= i_pkt_err || exhausted || starved;
        end
    end

endmodule : pkt_scatter

// File: verilog/pkt_gather.sv
`timescale 1ns/1ns

module pkt_gather (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_desc_valid,
    input  pkt_q_pkg::ptr_t  i_desc_ptr,
    input  pkt_q_pkg::len_t  i_desc_len,
    input  logic             i_desc_err,
    output logic             o_free,
    output pkt_q_pkg::ptr_t  o_free_ptr,
    output logic             o_pkt_valid,
    output pkt_q_pkg::data_t o_pkt_data,
    output logic             o_pkt_eop,
    buf_mem_if.gather        mem
);
    import pkt_q_pkg::*;

    gather_state_e    state;

    // Walk context
    ptr_t             cur_ptr;
    logic [OFS_W-1:0] ofs;
    len_t             remaining;
    logic             pkt_err;

    logic             last_word;
    logic             buf_end;

    // Read pipeline
    logic             rd_valid;
    logic             rd_eop;

    assign last_word = (remaining == len_t'(1));
    assign buf_end   = (ofs == OFS_W'(BUF_WORDS - 1)) || last_word;

    // ------------------------------
    // Memory side
    // ------------------------------
    assign mem.data_rd_addr = {cur_ptr, ofs};
    assign mem.link_rd_ptr  = cur_ptr;

    // Buffer goes back once its last address is issued
    assign o_free     = (state == GATHER_WALK) && buf_end;
    assign o_free_ptr = cur_ptr;

    // ------------------------------
    // FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state    <= GATHER_IDLE;
            rd_valid <= 1'b0;
            rd_eop   <= 1'b0;
        end else begin
            rd_valid <= (state == GATHER_WALK);
            rd_eop   <= (state == GATHER_WALK) && last_word;
            case (state)
                GATHER_IDLE: begin
                    // Empty chain, nothing to walk
                    if (i_desc_valid && (i_desc_len != '0)) begin
                        state <= GATHER_WALK;
                    end
                end
                GATHER_WALK: begin
                    if (last_word) begin
                        state <= GATHER_DRAIN;
                    end
                end
                GATHER_DRAIN: begin
                    state <= GATHER_IDLE;
                end
                default: begin
                    state <= GATHER_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == GATHER_IDLE) && i_desc_valid) begin
            cur_ptr   <= i_desc_ptr;
            ofs       <= '0;
            remaining <= i_desc_len;
            pkt_err   <= i_desc_err;
        end else if (state == GATHER_WALK) begin
            ofs       <= ofs + 1'b1;
            remaining <= remaining - 1'b1;
            if (buf_end) begin
                cur_ptr <= mem.link_rd_next;
            end
        end
    end

    // Errored packets are walked and freed but never shown
    assign o_pkt_valid = rd_valid && !pkt_err;
    assign o_pkt_data  = mem.data_rd_data;
    assign o_pkt_eop   = o_pkt_valid && rd_eop;

endmodule : pkt_gather

// File: verilog/pkt_q_top.sv
`timescale 1ns/1ns

module pkt_q_top (
    input  logic             clk,
    input  logic             i_reset,
    output logic             o_init_done,

    // Packet in
    input  logic             i_pkt_valid,
    input  pkt_q_pkg::data_t i_pkt_data,
    input  logic             i_pkt_eop,
    input  logic             i_pkt_err,

    // Descriptor to queue controller
    output logic             o_desc_valid,
    output pkt_q_pkg::ptr_t  o_desc_ptr,
    output pkt_q_pkg::len_t  o_desc_len,
    output logic             o_desc_err,

    // Descriptor from queue controller
    input  logic             i_desc_valid,
    input  pkt_q_pkg::ptr_t  i_desc_ptr,
    input  pkt_q_pkg::len_t  i_desc_len,
    input  logic             i_desc_err,

    // Packet out
    output logic             o_pkt_valid,
    output pkt_q_pkg::data_t o_pkt_data,
    output logic             o_pkt_eop
);
    import pkt_q_pkg::*;

    // Allocator links
    logic  take;
    logic  free;
    ptr_t  free_ptr;
    ptr_t  head_ptr;
    logic  empty;

    buf_mem_if mem_if ();

    buf_store u_buf_store (
        .clk (clk),
        .mem (mem_if)
    );

    buf_allocator u_buf_allocator (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_take      (take),
        .i_free      (free),
        .i_free_ptr  (free_ptr),
        .o_head_ptr  (head_ptr),
        .o_empty     (empty),
        .o_init_done (o_init_done)
    );

    pkt_scatter u_pkt_scatter (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_init_done  (o_init_done),
        .i_pkt_valid  (i_pkt_valid),
        .i_pkt_data   (i_pkt_data),
        .i_pkt_eop    (i_pkt_eop),
        .i_pkt_err    (i_pkt_err),
        .i_head_ptr   (head_ptr),
        .i_empty      (empty),
        .o_take       (take),
        .o_desc_valid (o_desc_valid),
        .o_desc_ptr   (o_desc_ptr),
        .o_desc_len   (o_desc_len),
        .o_desc_err   (o_desc_err),
        .mem          (mem_if)
    );

    pkt_gather u_pkt_gather (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_desc_valid (i_desc_valid),
        .i_desc_ptr   (i_desc_ptr),
        .i_desc_len   (i_desc_len),
        .i_desc_err   (i_desc_err),
        .o_free       (free),
        .o_free_ptr   (free_ptr),
        .o_pkt_valid  (o_pkt_valid),
        .o_pkt_data   (o_pkt_data),
        .o_pkt_eop    (o_pkt_eop),
        .mem          (mem_if)
    );

endmodule : pkt_q_top

// File: verif/pkt_q_tb.sv
`timescale 1ns/1ns

module pkt_q_tb;
    import pkt_q_pkg::*;

    logic  clk = 1'b0;
    logic  i_reset = 1'b1;
    logic  o_init_done;
    logic  i_pkt_valid = 1'b0;
    data_t i_pkt_data = '0;
    logic  i_pkt_eop = 1'b0;
    logic  i_pkt_err = 1'b0;
    logic  o_desc_valid;
    ptr_t  o_desc_ptr;
    len_t  o_desc_len;
    logic  o_desc_err;
    logic  i_desc_valid = 1'b0;
    ptr_t  i_desc_ptr = '0;
    len_t  i_desc_len = '0;
    logic  i_desc_err = 1'b0;
    logic  o_pkt_valid;
    data_t o_pkt_data;
    logic  o_pkt_eop;

    int              error_count = 0;
    int              cycle = 0;
    int              eop_cycle = -100;
    int              ret_cycle = -100;
    int              out_idx = 0;
    int              trace_lines = 0;
    int unsigned     lcg_state = 67451;

    // Captured descriptors and expected output words {eop, data}
    ptr_t            desc_ptr_q[$];
    len_t            desc_len_q[$];
    logic            desc_err_q[$];
    logic [DATA_W:0] exp_q[$];
    logic [DATA_W:0] exp_word;

    // Free list in allocator order and the buffers held by each descriptor
    ptr_t            free_model_q[$];
    ptr_t            taken_q[$];
    int              chain_start_q[$];
    int              chain_bufs_q[$];

    pkt_q_top dut_i (
        .clk          (clk),
        .i_reset      (i_reset),
        .o_init_done  (o_init_done),
        .i_pkt_valid  (i_pkt_valid),
        .i_pkt_data   (i_pkt_data),
        .i_pkt_eop    (i_pkt_eop),
        .i_pkt_err    (i_pkt_err),
        .o_desc_valid (o_desc_valid),
        .o_desc_ptr   (o_desc_ptr),
        .o_desc_len   (o_desc_len),
        .o_desc_err   (o_desc_err),
        .i_desc_valid (i_desc_valid),
        .i_desc_ptr   (i_desc_ptr),
        .i_desc_len   (i_desc_len),
        .i_desc_err   (i_desc_err),
        .o_pkt_valid  (o_pkt_valid),
        .o_pkt_data   (o_pkt_data),
        .o_pkt_eop    (o_pkt_eop)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic drive_run(input data_t first, input int count, input logic eop,
                             input logic err);
        int gap;
        for (int i = 0; i < count; i++) begin
            gap = next_random() % 4;
            repeat (gap) begin
                @(posedge clk);
                i_pkt_valid <= 1'b0;
            end
            @(posedge clk);
            i_pkt_valid <= 1'b1;
            i_pkt_data  <= first + data_t'(i);
            i_pkt_eop   <= eop && (i == count - 1);
            i_pkt_err   <= err;
        end
        @(posedge clk);
        i_pkt_valid <= 1'b0;
        i_pkt_eop   <= 1'b0;
    endtask

    task automatic expect_descriptor(input int idx, input logic err, input int len);
        int waited;
        int bufs;
        waited = 0;
        // Stored words fill buffers taken from the head of the free list
        bufs = (len + BUF_WORDS - 1) / BUF_WORDS;
        chain_start_q.push_back(taken_q.size());
        for (int i = 0; i < bufs && free_model_q.size() > 0; i++) begin
            taken_q.push_back(free_model_q.pop_front());
        end
        chain_bufs_q.push_back(taken_q.size() - chain_start_q[idx]);
        while (desc_len_q.size() <= idx && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (desc_len_q.size() <= idx) begin
            $display("Descriptor %0d never came out of the scatter stage", idx);
            error_count++;
        end else begin
            compare_value("o_desc_err", err, desc_err_q[idx]);
            compare_value("o_desc_len", len, desc_len_q[idx]);
            if (chain_bufs_q[idx] > 0) begin
                compare_value("o_desc_ptr", taken_q[chain_start_q[idx]], desc_ptr_q[idx]);
            end
        end
    endtask

    // Hands a descriptor back and waits out its walk
    task automatic return_descriptor(input int idx);
        if (idx >= desc_len_q.size()) begin
            $display("Trace returns descriptor %0d, which never arrived", idx);
            error_count++;
        end else begin
            @(posedge clk);
            i_desc_valid <= 1'b1;
            i_desc_ptr   <= desc_ptr_q[idx];
            i_desc_len   <= desc_len_q[idx];
            i_desc_err   <= desc_err_q[idx];
            @(posedge clk);
            i_desc_valid <= 1'b0;
            // Buffers go back to the free list in chain order
            if (idx < chain_bufs_q.size()) begin
                for (int i = 0; i < chain_bufs_q[idx]; i++) begin
                    free_model_q.push_back(taken_q[chain_start_q[idx] + i]);
                end
            end
            repeat (int'(desc_len_q[idx]) + 2) @(posedge clk);
            if (exp_q.size() != 0) begin
                $display("%0d output words of descriptor %0d never appeared",
                         exp_q.size(), idx);
                error_count++;
                exp_q.delete();
            end
        end
    endtask

    // ------------------------------
    // Output monitor
    // ------------------------------
    always @(negedge clk) begin
        if (!i_reset) begin
            if ($isunknown({o_init_done, o_desc_valid, o_pkt_valid})) begin
                $display("Unknown value on o_init_done, o_desc_valid or o_pkt_valid at %0t ns",
                         $time);
                error_count++;
            end
            if (i_pkt_valid && i_pkt_eop) begin
                eop_cycle = cycle;
            end
            if (o_desc_valid) begin
                compare_value("o_desc_valid cycle", eop_cycle + 1, cycle);
                desc_ptr_q.push_back(o_desc_ptr);
                desc_len_q.push_back(o_desc_len);
                desc_err_q.push_back(o_desc_err);
            end
            if (i_desc_valid) begin
                ret_cycle = cycle;
                out_idx   = 0;
            end
            if (o_pkt_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected output word %0h at %0t ns", o_pkt_data, $time);
                    error_count++;
                end else begin
                    exp_word = exp_q.pop_front();
                    compare_value("o_pkt_data", exp_word[DATA_W-1:0], o_pkt_data);
                    compare_value("o_pkt_eop", exp_word[DATA_W], o_pkt_eop);
                    // First word two cycles after the return and one word per cycle after it
                    compare_value("o_pkt_valid cycle", ret_cycle + 2 + out_idx, cycle);
                    out_idx++;
                end
            end
        end
    end

    // ------------------------------
    // Watchdog
    // ------------------------------
    initial begin
        wait (trace_lines > 0);
        repeat (trace_lines * 40) @(posedge clk);
        $display("Watchdog expired after %0d cycles with %0d errors so far",
                 trace_lines * 40, error_count);
        $display("Test failed");
        $finish;
    end

    // ------------------------------
    // Trace player
    // ------------------------------
    initial begin
        int    fd;
        int    code;
        int    want;
        byte   op;
        string line;
        data_t first;
        int    count;
        int    eop;
        int    err;
        int    num;
        int    x_idx;
        int    wait_cycles;

        x_idx = 0;
        for (int i = 0; i < NUM_BUFS; i++) begin
            free_model_q.push_back(ptr_t'(i));
        end
        fd = $fopen("verif/pkt_q_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file verif/pkt_q_trace.txt");
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                trace_lines++;
            end
            $fclose(fd);
            fd = $fopen("verif/pkt_q_trace.txt", "r");
        end

        repeat (8) @(posedge clk);
        i_reset <= 1'b0;

        // Free list fill takes one cycle per buffer
        wait_cycles = 0;
        @(negedge clk);
        while (!o_init_done && wait_cycles < 4 * NUM_BUFS) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (o_init_done !== 1'b1) begin
            $display("o_init_done never rose after reset, no packets were sent");
            error_count++;
        end else begin
            compare_value("o_init_done delay", NUM_BUFS, wait_cycles);
        end

        if (fd != 0 && o_init_done === 1'b1) begin
            while ($fscanf(fd, " %c", op) == 1) begin
                want = 0;
                case (op)
                    "I": begin
                        code = $fscanf(fd, " %h %d %d %d", first, count, eop, err);
                        want = 4;
                        drive_run(first, count, eop[0], err[0]);
                    end
                    "X": begin
                        code = $fscanf(fd, " %d %d", err, count);
                        want = 2;
                        expect_descriptor(x_idx, err[0], count);
                        x_idx++;
                    end
                    "O": begin
                        code = $fscanf(fd, " %h %d %d", first, count, eop);
                        want = 3;
                        for (int i = 0; i < count; i++) begin
                            exp_q.push_back({eop[0] && (i == count - 1), first + data_t'(i)});
                        end
                    end
                    "R": begin
                        code = $fscanf(fd, " %d", num);
                        want = 1;
                        return_descriptor(num);
                    end
                    "#": begin
                        code = $fgets(line, fd);
                    end
                    default: begin
                        $display("Unknown trace line type '%c', line skipped", op);
                        error_count++;
                        code = $fgets(line, fd);
                    end
                endcase
                if (want != 0 && code != want) begin
                    $display("Trace line of type '%c' has %0d fields instead of %0d",
                             op, code, want);
                    error_count++;
                end
            end
            $fclose(fd);
        end

        compare_value("descriptor count", x_idx, desc_len_q.size());
        $display("Run finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : pkt_q_tb

// File: compile.f
verilog/pkt_q_pkg.sv
verilog/buf_mem_if.sv
verilog/buf_store.sv
verilog/buf_allocator.sv
verilog/pkt_scatter.sv
verilog/pkt_gather.sv
verilog/pkt_q_top.sv
verif/pkt_q_tb.sv

// File: Bender.yml
package:
  name: pkt_q

sources:
  - target: any(simulation, synthesis)
    files:
      - verilog/pkt_q_pkg.sv
      - verilog/buf_mem_if.sv
      - verilog/buf_store.sv
      - verilog/buf_allocator.sv
      - verilog/pkt_scatter.sv
      - verilog/pkt_gather.sv
      - verilog/pkt_q_top.sv

  - target: test
    files:
      - verif/pkt_q_tb.sv

// File: verif/pkt_q_trace.txt
# I first_word words eop err : drive a run of words, eop on the run's last word
# X err len : expected descriptor, in arrival order
# O first_word words eop : expected output run, R n : return descriptor n
# Single word packet
I 10000000 1 1 0
X 0 1
# Nine words over three buffers
I 20000000 4 0 0
I 20000004 5 1 0
X 0 9
# Errored packet
I 30000000 3 1 1
X 1 3
# Runs out of buffers with 11 left free
I 40000000 40 0 0
I 40000028 30 1 0
X 1 44
# Reverse order return
R 3
R 2
O 20000000 9 1
R 1
O 10000000 1 1
R 0
# Whole pool once every buffer is back
I 50000000 64 1 0
X 0 64
O 50000000 32 0
O 50000020 32 1
R 4
